// File: bench/fc_mem_model.sv
/* Behavioral memory responder for one side of a core bus
   Grants on an enable input and answers each grant in order */

`timescale 1ns/1ns

module fc_mem_model (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic [31:0]          tag_i,
    input  logic                 gnt_en_i,
    input  logic [1:0]           delay_i,
    input  fc_mem_pkg::mem_req_t req_i,
    output fc_mem_pkg::mem_rsp_t rsp_o
);

    logic        gnt;
    logic        rvalid_q;
    logic [31:0] rdata_q;
    int unsigned cyc_q;

    // Pending answers and the cycle each one becomes due
    logic [31:0] data_q[$];
    int unsigned due_q[$];

    assign gnt   = req_i.req & gnt_en_i;
    assign rsp_o = {gnt, rvalid_q, rdata_q, 1'b0};

    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rvalid_q <= 1'b0;
            rdata_q  <= '0;
            cyc_q    <= 0;
            data_q.delete();
            due_q.delete();
        end else begin
            cyc_q <= cyc_q + 1;
            // Head of the queue answers once its delay has run out
            if (due_q.size() > 0 && due_q[0] <= cyc_q) begin
                rvalid_q <= 1'b1;
                rdata_q  <= data_q.pop_front();
                void'(due_q.pop_front());
            end else begin
                rvalid_q <= 1'b0;
            end
            if (gnt) begin
                data_q.push_back(req_i.addr ^ tag_i);
                due_q.push_back(cyc_q + 32'(delay_i));
            end
        end
    end

endmodule

// File: bench/tb_fc_core_link.sv
/* Testbench for the fabric controller glue
   Clock, reset, memory models, stimulus table, checks and timeout */

`timescale 1ns/1ns

module tb_fc_core_link;

    typedef struct packed {
        logic        bus_data;
        logic [31:0] addr;
        logic        we;
        logic        exp_scm;
        logic [4:0]  irq_id;
        logic        irq_lvl;
        logic        ack;
        logic [31:0] exp_vec;
        logic        exp_irq_req;
    } row_t;

    localparam int n_rows = 12;
    localparam int max_cycles = n_rows * 20;

    logic clk_i;
    logic rst_ni;
    logic fetch_en_i;
    logic eu_fetch_en_i;
    logic [31:0] boot_addr_i;
    logic core_fetch_en_o;
    logic [31:0] core_boot_addr_o;
    fc_mem_pkg::mem_req_t core_instr_req, core_data_req;
    fc_mem_pkg::mem_rsp_t core_instr_rsp, core_data_rsp;
    fc_mem_pkg::mem_req_t l2_instr_req, scm_instr_req, l2_data_req, scm_data_req;
    fc_mem_pkg::mem_rsp_t l2_instr_rsp, scm_instr_rsp, l2_data_rsp, scm_data_rsp;
    logic eu_irq_req_i;
    logic [4:0] eu_irq_id_i;
    logic core_irq_ack_i;
    logic core_irq_req_o;
    logic [31:0] core_irq_o;

    logic [3:0] gnt_en;
    logic [7:0] delays;
    integer seed;
    int cycles;
    int instr_sent;
    int data_sent;
    int instr_rvalids;
    int data_rvalids;
    row_t tbl [n_rows];

    always #4 clk_i = ~clk_i;

    fc_core_link dut (
        .clk_i(clk_i), .rst_ni(rst_ni),
        .fetch_en_i(fetch_en_i), .eu_fetch_en_i(eu_fetch_en_i), .boot_addr_i(boot_addr_i),
        .core_fetch_en_o(core_fetch_en_o), .core_boot_addr_o(core_boot_addr_o),
        .core_instr_req_i(core_instr_req), .core_instr_rsp_o(core_instr_rsp),
        .core_data_req_i(core_data_req), .core_data_rsp_o(core_data_rsp),
        .l2_instr_req_o(l2_instr_req), .scm_instr_req_o(scm_instr_req),
        .l2_data_req_o(l2_data_req), .scm_data_req_o(scm_data_req),
        .l2_instr_rsp_i(l2_instr_rsp), .scm_instr_rsp_i(scm_instr_rsp),
        .l2_data_rsp_i(l2_data_rsp), .scm_data_rsp_i(scm_data_rsp),
        .eu_irq_req_i(eu_irq_req_i), .eu_irq_id_i(eu_irq_id_i),
        .core_irq_ack_i(core_irq_ack_i),
        .core_irq_req_o(core_irq_req_o), .core_irq_o(core_irq_o)
    );

    // Memory models with the L2 tag A and the scratchpad tag 5
    fc_mem_model u_l2_instr (clk_i, rst_ni, 32'hA000_0000, gnt_en[0], delays[1:0],
                             l2_instr_req, l2_instr_rsp);
    fc_mem_model u_scm_instr (clk_i, rst_ni, 32'h5000_0000, gnt_en[1], delays[3:2],
                              scm_instr_req, scm_instr_rsp);
    fc_mem_model u_l2_data (clk_i, rst_ni, 32'hA000_0000, gnt_en[2], delays[5:4],
                            l2_data_req, l2_data_rsp);
    fc_mem_model u_scm_data (clk_i, rst_ni, 32'h5000_0000, gnt_en[3], delays[7:6],
                             scm_data_req, scm_data_rsp);

    //************************************************************
    // Random grants, delays and boot inputs every cycle
    //************************************************************
    always @(posedge clk_i) begin
        gnt_en        <= 4'($random(seed));
        delays[1:0]   <= 2'({$random(seed)} % 3 + 1);
        delays[3:2]   <= 2'({$random(seed)} % 3 + 1);
        delays[5:4]   <= 2'({$random(seed)} % 3 + 1);
        delays[7:6]   <= 2'({$random(seed)} % 3 + 1);
        boot_addr_i   <= $random(seed);
        fetch_en_i    <= 1'($random(seed));
        eu_fetch_en_i <= 1'($random(seed));
    end

    // Responses taken by the core on each bus
    always @(posedge clk_i) begin
        if (core_instr_rsp.rvalid) begin
            instr_rvalids <= instr_rvalids + 1;
        end
        if (core_data_rsp.rvalid) begin
            data_rvalids <= data_rvalids + 1;
        end
    end

    // Run limit
    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout, the DUT did not finish within %0d cycles", max_cycles);
            $display("test failed");
            $fatal(1);
        end
    end

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            $display("test failed");
            $fatal(1);
        end
    endtask

    // Request fields reach both sides whatever the chosen target
    task automatic check_side_fields(input string side, input fc_mem_pkg::mem_req_t got,
                                     input row_t r);
        compare_word({side, ".addr"}, got.addr, r.addr);
        compare_word({side, ".wdata"}, got.wdata, ~r.addr);
        compare_word({side, " {we,be}"}, {27'd0, got.we, got.be}, {27'd0, r.we, 4'hF});
    endtask

    task automatic check_outputs(input row_t r);
        logic [31:0] exp_scm_bits;
        logic [31:0] exp_fetch;
        exp_scm_bits = {28'd0, r.bus_data & r.exp_scm, r.bus_data & ~r.exp_scm,
                        ~r.bus_data & r.exp_scm, ~r.bus_data & ~r.exp_scm};
        exp_fetch = (fetch_en_i === 1'b1 && eu_fetch_en_i === 1'b1) ? 32'd1 : 32'd0;
        compare_word("side req {scm_d,l2_d,scm_i,l2_i}",
                     {28'd0, scm_data_req.req, l2_data_req.req,
                      scm_instr_req.req, l2_instr_req.req}, exp_scm_bits);
        if (r.bus_data) begin
            check_side_fields("l2_data_req_o", l2_data_req, r);
            check_side_fields("scm_data_req_o", scm_data_req, r);
        end else begin
            check_side_fields("l2_instr_req_o", l2_instr_req, r);
            check_side_fields("scm_instr_req_o", scm_instr_req, r);
        end
        compare_word("core_irq_o", core_irq_o, r.exp_vec);
        compare_word("core_irq_req_o", {31'd0, core_irq_req_o}, {31'd0, r.exp_irq_req});
        compare_word("core_boot_addr_o", core_boot_addr_o, {boot_addr_i[31:8], 8'h00});
        compare_word("core_fetch_en_o", {31'd0, core_fetch_en_o}, exp_fetch);
    endtask

    task automatic run_row(input row_t r);
        fc_mem_pkg::mem_rsp_t got_rsp;
        logic [31:0]          exp_tag;
        @(posedge clk_i);
        if (r.bus_data) begin
            core_data_req <= {1'b1, r.addr, r.we, 4'hF, ~r.addr};
        end else begin
            core_instr_req <= {1'b1, r.addr, r.we, 4'hF, ~r.addr};
        end
        eu_irq_req_i   <= r.irq_lvl;
        eu_irq_id_i    <= r.irq_id;
        core_irq_ack_i <= r.ack;
        @(negedge clk_i);
        check_outputs(r);
        // Request holds until granted while the ack drops after one cycle
        while (!(r.bus_data ? core_data_rsp.gnt : core_instr_rsp.gnt)) begin
            @(posedge clk_i);
            core_irq_ack_i <= 1'b0;
            @(negedge clk_i);
        end
        @(posedge clk_i);
        core_irq_ack_i     <= 1'b0;
        core_data_req.req  <= 1'b0;
        core_instr_req.req <= 1'b0;
        if (r.bus_data) begin
            data_sent++;
        end else begin
            instr_sent++;
        end
        @(negedge clk_i);
        while (!(r.bus_data ? core_data_rsp.rvalid : core_instr_rsp.rvalid)) begin
            @(negedge clk_i);
        end
        got_rsp = r.bus_data ? core_data_rsp : core_instr_rsp;
        exp_tag = r.exp_scm ? 32'h5000_0000 : 32'hA000_0000;
        compare_word("core rsp rdata", got_rsp.rdata, r.addr ^ exp_tag);
        compare_word("core rsp err", {31'd0, got_rsp.err}, 32'd0);
    endtask

    initial begin
        seed           = 32'hf6ae;
        cycles         = 0;
        instr_sent     = 0;
        data_sent      = 0;
        instr_rvalids  = 0;
        data_rvalids   = 0;
        clk_i          = 1'b0;
        rst_ni         = 1'b0;
        fetch_en_i     = 1'b0;
        eu_fetch_en_i  = 1'b0;
        boot_addr_i    = '0;
        core_instr_req = '0;
        core_data_req  = '0;
        eu_irq_req_i   = 1'b0;
        eu_irq_id_i    = '0;
        core_irq_ack_i = 1'b0;
        gnt_en         = '0;
        delays         = 8'h55;

        // bus, addr, we, scm, id, lvl, ack, vector, core irq req
        tbl[0]  = '{1'b0, 32'h1C00_8000, 1'b0, 1'b1, 5'd0,  1'b0, 1'b0, 32'h0, 1'b0};
        tbl[1]  = '{1'b1, 32'h1C00_FFFC, 1'b1, 1'b1, 5'd3,  1'b1, 1'b0, 32'h8, 1'b1};
        tbl[2]  = '{1'b0, 32'h1C01_0000, 1'b0, 1'b0, 5'd7,  1'b1, 1'b0, 32'h80, 1'b1};
        tbl[3]  = '{1'b1, 32'h0000_8000, 1'b0, 1'b1, 5'd11, 1'b1, 1'b1, 32'h800, 1'b1};
        tbl[4]  = '{1'b0, 32'h0000_7FFC, 1'b0, 1'b0, 5'd16, 1'b1, 1'b0, 32'h1_0000, 1'b0};
        tbl[5]  = '{1'b1, 32'h0001_0000, 1'b1, 1'b0, 5'd31, 1'b1, 1'b0, 32'h8000_0000, 1'b0};
        tbl[6]  = '{1'b0, 32'h0000_FFFC, 1'b0, 1'b1, 5'd5,  1'b0, 1'b0, 32'h0, 1'b0};
        tbl[7]  = '{1'b1, 32'h1C00_7FFC, 1'b0, 1'b0, 5'd20, 1'b0, 1'b0, 32'h0, 1'b0};
        tbl[8]  = '{1'b0, 32'h1A10_0000, 1'b0, 1'b0, 5'd5,  1'b1, 1'b0, 32'h0, 1'b1};
        tbl[9]  = '{1'b1, 32'h1C00_C010, 1'b1, 1'b1, 5'd0,  1'b1, 1'b1, 32'h0, 1'b1};
        tbl[10] = '{1'b0, 32'h0000_9234, 1'b0, 1'b1, 5'd25, 1'b0, 1'b0, 32'h0, 1'b0};
        tbl[11] = '{1'b1, 32'hFFFF_FFFC, 1'b0, 1'b0, 5'd12, 1'b1, 1'b0, 32'h0, 1'b1};

        repeat (8) @(posedge clk_i);
        rst_ni <= 1'b1;
        for (int i = 0; i < n_rows; i++) begin
            run_row(tbl[i]);
        end
        // One response per request and none to spare
        @(posedge clk_i);
        @(negedge clk_i);
        compare_word("instr rvalid count", instr_rvalids, instr_sent);
        compare_word("data rvalid count", data_rvalids, data_sent);
        $display("test passed");
        $finish;
    end

endmodule

// File: run.sh
#!/bin/bash
# Build and run the testbench with Verilator, pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_fc_core_link -f vlog.f -o sim_fc_core_link \
    && out=$(./obj_dir/sim_fc_core_link) \
    ; echo "$out" \
    && echo "$out" | grep -qx "test passed" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// File: src/fc_core_link.sv
/* Fabric controller glue between the core and its surroundings
   Instruction and data routers, interrupt adapter, boot control */

`timescale 1ns/1ns

module fc_core_link (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,

    // Boot control
    input  logic                                 fetch_en_i,
    input  logic                                 eu_fetch_en_i,
    input  logic [fc_mem_pkg::addr_w-1:0]        boot_addr_i,
    output logic                                 core_fetch_en_o,
    output logic [fc_mem_pkg::addr_w-1:0]        core_boot_addr_o,

    // Core side buses
    input  fc_mem_pkg::mem_req_t                 core_instr_req_i,
    output fc_mem_pkg::mem_rsp_t                 core_instr_rsp_o,
    input  fc_mem_pkg::mem_req_t                 core_data_req_i,
    output fc_mem_pkg::mem_rsp_t                 core_data_rsp_o,

    // Memory side buses
    output fc_mem_pkg::mem_req_t                 l2_instr_req_o,
    output fc_mem_pkg::mem_req_t                 scm_instr_req_o,
    output fc_mem_pkg::mem_req_t                 l2_data_req_o,
    output fc_mem_pkg::mem_req_t                 scm_data_req_o,
    input  fc_mem_pkg::mem_rsp_t                 l2_instr_rsp_i,
    input  fc_mem_pkg::mem_rsp_t                 scm_instr_rsp_i,
    input  fc_mem_pkg::mem_rsp_t                 l2_data_rsp_i,
    input  fc_mem_pkg::mem_rsp_t                 scm_data_rsp_i,

    // Interrupts
    input  logic                                 eu_irq_req_i,
    input  logic [fc_irq_pkg::irq_id_w-1:0]      eu_irq_id_i,
    input  logic                                 core_irq_ack_i,
    output logic                                 core_irq_req_o,
    output logic [fc_irq_pkg::irq_lines-1:0]     core_irq_o
);

    //**********************************************************
    // Boot control
    //**********************************************************
    // Ibex adds its own reset offset to the boot vector
    assign core_boot_addr_o = boot_addr_i & fc_irq_pkg::boot_align_mask;
    assign core_fetch_en_o  = fetch_en_i & eu_fetch_en_i;

    //**********************************************************
    // Bus routing, L2 or scratchpad
    //**********************************************************
    fc_mem_router u_instr_router (
        .clk_i      ( clk_i            ),
        .rst_ni     ( rst_ni           ),
        .core_req_i ( core_instr_req_i ),
        .core_rsp_o ( core_instr_rsp_o ),
        .l2_req_o   ( l2_instr_req_o   ),
        .l2_rsp_i   ( l2_instr_rsp_i   ),
        .scm_req_o  ( scm_instr_req_o  ),
        .scm_rsp_i  ( scm_instr_rsp_i  )
    );

    fc_mem_router u_data_router (
        .clk_i      ( clk_i           ),
        .rst_ni     ( rst_ni          ),
        .core_req_i ( core_data_req_i ),
        .core_rsp_o ( core_data_rsp_o ),
        .l2_req_o   ( l2_data_req_o   ),
        .l2_rsp_i   ( l2_data_rsp_i   ),
        .scm_req_o  ( scm_data_req_o  ),
        .scm_rsp_i  ( scm_data_rsp_i  )
    );

    //**********************************************************
    // Interrupts from the event unit
    //**********************************************************
    fc_irq_adapter u_irq_adapter (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .eu_irq_req_i   ( eu_irq_req_i   ),
        .eu_irq_id_i    ( eu_irq_id_i    ),
        .core_irq_ack_i ( core_irq_ack_i ),
        .core_irq_req_o ( core_irq_req_o ),
        .core_irq_o     ( core_irq_o     )
    );

endmodule

// File: src/fc_irq_adapter.sv
/* Interrupt adapter for an Ibex-style core
   ID to line vector decode and the request level handshake */

`timescale 1ns/1ns

module fc_irq_adapter (
    input  logic                              clk_i,
    input  logic                              rst_ni,

    input  logic                              eu_irq_req_i,
    input  logic [fc_irq_pkg::irq_id_w-1:0]   eu_irq_id_i,
    input  logic                              core_irq_ack_i,

    output logic                              core_irq_req_o,
    output logic [fc_irq_pkg::irq_lines-1:0]  core_irq_o
);

    fc_irq_pkg::irq_state_e state_q;
    fc_irq_pkg::irq_state_e state_d;
    logic                   req_prev_q;
    logic                   req_rise;
    logic                   req_fall;
    logic                   id_legal;
    logic [31:0]            id_wide;

    //**********************************************************
    // Line vector decode
    //**********************************************************
    // ID widened to the width of the line positions
    assign id_wide  = 32'(eu_irq_id_i);
    assign id_legal = (id_wide == fc_irq_pkg::irq_sw_line)    ||
                      (id_wide == fc_irq_pkg::irq_timer_line) ||
                      (id_wide == fc_irq_pkg::irq_ext_line)   ||
                      (id_wide >= fc_irq_pkg::irq_fast_first);

    always_comb begin
        core_irq_o = '0;
        if (eu_irq_req_i && id_legal) begin
            core_irq_o[eu_irq_id_i] = 1'b1;
        end
    end

    //**********************************************************
    // Request handshake
    //**********************************************************
    assign req_rise =  eu_irq_req_i & ~req_prev_q;
    assign req_fall = ~eu_irq_req_i &  req_prev_q;

    always_comb begin
        state_d        = state_q;
        core_irq_req_o = 1'b0;
        case (state_q)
            fc_irq_pkg::IRQ_IDLE: begin
                core_irq_req_o = eu_irq_req_i;
                if (req_rise) begin
                    state_d = fc_irq_pkg::IRQ_PENDING;
                end
            end
            fc_irq_pkg::IRQ_PENDING: begin
                // Held until the core takes it
                core_irq_req_o = 1'b1;
                if (core_irq_ack_i) begin
                    state_d = fc_irq_pkg::IRQ_WAIT_LOW;
                end
            end
            fc_irq_pkg::IRQ_WAIT_LOW: begin
                // Low until the source itself drops
                if (req_fall) begin
                    state_d = fc_irq_pkg::IRQ_IDLE;
                end
            end
            default: begin
                state_d = fc_irq_pkg::IRQ_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= fc_irq_pkg::IRQ_IDLE;
            req_prev_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            req_prev_q <= eu_irq_req_i;
        end
    end

endmodule

// File: src/fc_irq_pkg.sv
/* Interrupt and boot definitions for the fabric controller glue
   ID and line widths, legal lines, boot mask and handshake states */

package fc_irq_pkg;

    // Event unit ID and core line vector widths
    localparam int unsigned irq_id_w  = 5;
    localparam int unsigned irq_lines = 32;

    //**********************************************************
    // Legal line positions on the Ibex-style core
    //**********************************************************
    localparam int unsigned irq_sw_line    = 3;
    localparam int unsigned irq_timer_line = 7;
    localparam int unsigned irq_ext_line   = 11;
    // Every line from here up to the top is a fast line
    localparam int unsigned irq_fast_first = 16;

    // Boot vector sits on a 256-byte boundary
    localparam logic [31:0] boot_align_mask = 32'hFFFF_FF00;

    // Request level handshake towards the core
    typedef enum logic [1:0] {
        IRQ_IDLE,
        IRQ_PENDING,
        IRQ_WAIT_LOW
    } irq_state_e;

endpackage

// File: src/fc_mem_pkg.sv
/* Core bus definitions for the fabric controller glue
   Request and response structs, bus widths and scratchpad windows */

package fc_mem_pkg;

    // Bus widths
    localparam int unsigned addr_w = 32;
    localparam int unsigned data_w = 32;
    localparam int unsigned be_w   = 4;

    //**********************************************************
    // Scratchpad windows, start inclusive and end exclusive
    //**********************************************************
    localparam logic [addr_w-1:0] scm_start       = 32'h1C00_8000;
    localparam logic [addr_w-1:0] scm_end         = 32'h1C01_0000;

    // Low alias of the same scratchpad
    localparam logic [addr_w-1:0] scm_alias_start = 32'h0000_8000;
    localparam logic [addr_w-1:0] scm_alias_end   = 32'h0001_0000;

    // Request from the core, held stable until granted
    typedef struct packed {
        logic              req;
        logic [addr_w-1:0] addr;
        logic              we;
        logic [be_w-1:0]   be;
        logic [data_w-1:0] wdata;
    } mem_req_t;

    // Grant in the request cycle, rvalid with data later
    typedef struct packed {
        logic              gnt;
        logic              rvalid;
        logic [data_w-1:0] rdata;
        logic              err;
    } mem_rsp_t;

endpackage

// File: src/fc_mem_router.sv
/* Core bus router between the L2 port and the scratchpad port
   Address decode, grant steering and an in-order response record */

`timescale 1ns/1ns

module fc_mem_router (
    input  logic                 clk_i,
    input  logic                 rst_ni,

    input  fc_mem_pkg::mem_req_t core_req_i,
    output fc_mem_pkg::mem_rsp_t core_rsp_o,

    output fc_mem_pkg::mem_req_t l2_req_o,
    input  fc_mem_pkg::mem_rsp_t l2_rsp_i,

    output fc_mem_pkg::mem_req_t scm_req_o,
    input  fc_mem_pkg::mem_rsp_t scm_rsp_i
);

    logic                 sel_scm;
    logic                 in_scm;
    logic                 in_alias;
    logic                 full;
    logic                 empty;
    logic                 push;
    logic                 pop;
    logic                 head_scm;
    fc_mem_pkg::mem_rsp_t head_rsp;

    // Record of granted targets, 1 means scratchpad
    logic [1:0]           side_q;
    logic                 wr_ptr_q;
    logic                 rd_ptr_q;
    logic [1:0]           count_q;

    //**********************************************************
    // Address decode
    //**********************************************************
    assign in_scm   = (core_req_i.addr >= fc_mem_pkg::scm_start) &&
                      (core_req_i.addr <  fc_mem_pkg::scm_end);
    assign in_alias = (core_req_i.addr >= fc_mem_pkg::scm_alias_start) &&
                      (core_req_i.addr <  fc_mem_pkg::scm_alias_end);
    assign sel_scm  = in_scm | in_alias;

    assign full  = (count_q == 2'd2);
    assign empty = (count_q == 2'd0);

    // Fields go to both sides, only the chosen one sees req
    always_comb begin
        l2_req_o      = core_req_i;
        scm_req_o     = core_req_i;
        l2_req_o.req  = core_req_i.req & ~sel_scm & ~full;
        scm_req_o.req = core_req_i.req &  sel_scm & ~full;
    end

    // Response comes from whichever side sits at the head of the record
    assign head_scm = side_q[rd_ptr_q];
    assign head_rsp = head_scm ? scm_rsp_i : l2_rsp_i;

    always_comb begin
        core_rsp_o.gnt    = ~full & (sel_scm ? scm_rsp_i.gnt : l2_rsp_i.gnt);
        core_rsp_o.rvalid = ~empty & head_rsp.rvalid;
        core_rsp_o.rdata  = head_rsp.rdata;
        core_rsp_o.err    = head_rsp.err;
    end

    assign push = core_req_i.req & core_rsp_o.gnt;
    assign pop  = core_rsp_o.rvalid;

    //**********************************************************
    // In-order target record
    //**********************************************************
    always_ff @(posedge clk_i) begin
        if (push) begin
            side_q[wr_ptr_q] <= sel_scm;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr_q <= ~wr_ptr_q;
            end
            if (pop) begin
                rd_ptr_q <= ~rd_ptr_q;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 2'd1;
                2'b01:   count_q <= count_q - 2'd1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

// File: vlog.f
src/fc_mem_pkg.sv
src/fc_irq_pkg.sv
src/fc_mem_router.sv
src/fc_irq_adapter.sv
src/fc_core_link.sv
bench/fc_mem_model.sv
bench/tb_fc_core_link.sv
